// ==== cdc_fifo_pkg.sv ====
/*
 * Shared sizes for the dual-clock FIFO.
 * Every FIFO module takes these by a wildcard import in its header.
 * Change addr_width to resize the storage. The pointers follow it.
 */

package cdc_fifo_pkg;

    // Width of one stored word.
    localparam int elem_width = 8;

    // Address bits into the storage array.
    localparam int addr_width = 2;

    // Words held by the FIFO.
    localparam int depth = 2 ** addr_width;

    // Pointer width. The extra MSB tells a full FIFO from an empty one.
    localparam int ptr_width = addr_width + 1;

    // Flops in each pointer synchronizer.
    localparam int sync_stages = 2;

endpackage

// ==== fifo_mem.sv ====
/*
 * Dual-clock storage array of the FIFO.
 * Written on clk_in_i when wr_en_i is high.
 * Read combinationally by rd_addr_i, so the oldest word falls through
 * to rd_data_o without a read clock.
 */

`timescale 1ns/1ps

module fifo_mem import cdc_fifo_pkg::*; (
    input  logic                  clk_in_i,   // Write clock.
    input  logic                  wr_en_i,
    input  logic [addr_width-1:0] wr_addr_i,
    input  logic [elem_width-1:0] wr_data_i,
    input  logic [addr_width-1:0] rd_addr_i,  // From the read domain.
    output logic [elem_width-1:0] rd_data_o
);

    // Storage words. Payload only.
    logic [elem_width-1:0] mem [depth];

    // Write port.
    always_ff @(posedge clk_in_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;  // Slot is free, guarded by full.
        end
    end

    // Asynchronous read port.
    assign rd_data_o = mem[rd_addr_i];

endmodule

// ==== ptr_sync.sv ====
/*
 * Multi-stage synchronizer for a Gray-coded FIFO pointer.
 * Clocked by the destination domain. clk_in_i is that clock here.
 * Only one bit of gray_i moves per source step, so gray_o always
 * holds a value the source pointer really had.
 */

`timescale 1ns/1ps

module ptr_sync import cdc_fifo_pkg::*; (
    input  logic                 clk_in_i,  // Destination clock.
    input  logic                 arst_n_i,
    input  logic [ptr_width-1:0] gray_i,    // Registered in source domain.
    output logic [ptr_width-1:0] gray_o
);

    // Flop chain. Stage 0 may go metastable.
    logic [ptr_width-1:0] stage_q [sync_stages];

    always_ff @(posedge clk_in_i or negedge arst_n_i) begin
        if (~arst_n_i) begin
            for (int i = 0; i < sync_stages; i++) begin
                stage_q[i] <= '0;  // Pointers start at zero.
            end
        end
        else begin
            stage_q[0] <= gray_i;  // Capture from other domain.
            for (int i = 1; i < sync_stages; i++) begin
                stage_q[i] <= stage_q[i-1];  // Settle.
            end
        end
    end

    // Last stage is safe to use.
    assign gray_o = stage_q[sync_stages-1];

endmodule

// ==== fifo_wr_ctrl.sv ====
/*
 * Write-side control of the dual-clock FIFO.
 * Keeps the binary write pointer and its registered Gray copy.
 * Full is found by comparing the Gray copy with the synchronized
 * read pointer. data_in_ready_o drops while full.
 */

`timescale 1ns/1ps

module fifo_wr_ctrl import cdc_fifo_pkg::*; (
    input  logic                  clk_in_i,
    input  logic                  arst_n_i,
    input  logic                  data_in_valid_i,
    output logic                  data_in_ready_o,
    input  logic [ptr_width-1:0]  rd_gray_sync_i,  // Read pointer, synced.
    output logic                  wr_en_o,
    output logic [addr_width-1:0] wr_addr_o,
    output logic [ptr_width-1:0]  wr_gray_o         // To the read domain.
);

    logic [ptr_width-1:0] wr_bin_q;       // Binary write pointer.
    logic [ptr_width-1:0] wr_bin_next;
    logic [ptr_width-1:0] wr_gray_q;      // Gray copy. Crosses domains.
    logic [ptr_width-1:0] wr_gray_next;
    logic [ptr_width-1:0] full_gray;      // Write Gray value meaning full.
    logic                 full;

    // Full when the writer is one lap ahead of the reader.
    // In Gray code that is the top two bits inverted.
    assign full_gray = {~rd_gray_sync_i[ptr_width-1:ptr_width-2],
                        rd_gray_sync_i[ptr_width-3:0]};
    assign full      = (wr_gray_q == full_gray);

    assign data_in_ready_o = ~full;
    assign wr_en_o         = data_in_valid_i & data_in_ready_o;  // Accept.
    assign wr_addr_o       = wr_bin_q[addr_width-1:0];           // Drop wrap bit.
    assign wr_gray_o       = wr_gray_q;

    // Next pointer values.
    assign wr_bin_next  = wr_bin_q + ptr_width'(1);
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    // Both pointers move together on an accepted word.
    always_ff @(posedge clk_in_i or negedge arst_n_i) begin
        if (~arst_n_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
        end
        else begin
            if (wr_en_o) begin
                wr_bin_q  <= wr_bin_next;
                wr_gray_q <= wr_gray_next;  // Glitch-free source for sync.
            end
        end
    end

endmodule

// ==== fifo_rd_ctrl.sv ====
/*
 * Read-side control of the dual-clock FIFO.
 * Keeps the binary read pointer and its registered Gray copy.
 * Empty is found by comparing the Gray copy with the synchronized
 * write pointer. data_out_valid_o is high while not empty.
 */

`timescale 1ns/1ps

module fifo_rd_ctrl import cdc_fifo_pkg::*; (
    input  logic                  clk_out_i,
    input  logic                  arst_n_i,
    input  logic                  data_out_ready_i,
    output logic                  data_out_valid_o,
    input  logic [ptr_width-1:0]  wr_gray_sync_i,  // Write pointer, synced.
    output logic [addr_width-1:0] rd_addr_o,
    output logic [ptr_width-1:0]  rd_gray_o         // To the write domain.
);

    logic [ptr_width-1:0] rd_bin_q;       // Binary read pointer.
    logic [ptr_width-1:0] rd_bin_next;
    logic [ptr_width-1:0] rd_gray_q;      // Gray copy. Crosses domains.
    logic [ptr_width-1:0] rd_gray_next;
    logic                 empty;
    logic                 rd_adv;         // Word consumed this edge.

    // Empty when both pointers match including the wrap bit.
    assign empty = (rd_gray_q == wr_gray_sync_i);

    assign data_out_valid_o = ~empty;
    assign rd_adv           = data_out_valid_o & data_out_ready_i;
    assign rd_addr_o        = rd_bin_q[addr_width-1:0];  // Oldest word.
    assign rd_gray_o        = rd_gray_q;

    // Next pointer values.
    assign rd_bin_next  = rd_bin_q + ptr_width'(1);
    assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

    // Advance on handshake. Otherwise output holds.
    always_ff @(posedge clk_out_i or negedge arst_n_i) begin
        if (~arst_n_i) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
        end
        else begin
            if (rd_adv) begin
                rd_bin_q  <= rd_bin_next;
                rd_gray_q <= rd_gray_next;  // One bit flips per step.
            end
        end
    end

endmodule

// ==== async_fifo.sv ====
/*
 * Dual-clock FIFO top level.
 * Words enter on clk_in_i through a valid/ready pair and leave on
 * clk_out_i through a first-word-fall-through valid/ready pair.
 * Each side's Gray pointer reaches the other side through its own
 * ptr_sync. One asynchronous reset clears both domains.
 */

`timescale 1ns/1ps

module async_fifo import cdc_fifo_pkg::*; (
    input  logic                  arst_n_i,

    input  logic                  clk_in_i,
    input  logic [elem_width-1:0] data_in_i,
    input  logic                  data_in_valid_i,
    output logic                  data_in_ready_o,

    input  logic                  clk_out_i,
    output logic [elem_width-1:0] data_out_o,
    output logic                  data_out_valid_o,
    input  logic                  data_out_ready_i
);

    logic                  wr_en;         // Write strobe into storage.
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] rd_addr;
    logic [ptr_width-1:0]  wr_gray;       // clk_in_i domain.
    logic [ptr_width-1:0]  rd_gray;       // clk_out_i domain.
    logic [ptr_width-1:0]  wr_gray_sync;  // wr_gray seen in clk_out_i.
    logic [ptr_width-1:0]  rd_gray_sync;  // rd_gray seen in clk_in_i.

    // Write side.
    fifo_wr_ctrl u_wr_ctrl (
        .clk_in_i        (clk_in_i),
        .arst_n_i        (arst_n_i),
        .data_in_valid_i (data_in_valid_i),
        .data_in_ready_o (data_in_ready_o),
        .rd_gray_sync_i  (rd_gray_sync),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .wr_gray_o       (wr_gray)
    );

    // Read side.
    fifo_rd_ctrl u_rd_ctrl (
        .clk_out_i        (clk_out_i),
        .arst_n_i         (arst_n_i),
        .data_out_ready_i (data_out_ready_i),
        .data_out_valid_o (data_out_valid_o),
        .wr_gray_sync_i   (wr_gray_sync),
        .rd_addr_o        (rd_addr),
        .rd_gray_o        (rd_gray)
    );

    // Write pointer into the read domain.
    ptr_sync u_wr_sync (
        .clk_in_i (clk_out_i),
        .arst_n_i (arst_n_i),
        .gray_i   (wr_gray),
        .gray_o   (wr_gray_sync)
    );

    // Read pointer into the write domain.
    ptr_sync u_rd_sync (
        .clk_in_i (clk_in_i),
        .arst_n_i (arst_n_i),
        .gray_i   (rd_gray),
        .gray_o   (rd_gray_sync)
    );

    // Storage. Read data falls straight through to the output.
    fifo_mem u_mem (
        .clk_in_i  (clk_in_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (data_in_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (data_out_o)
    );

endmodule

// ==== async_fifo_asserts.sv ====
/*
 * Concurrent checks on the FIFO's pointers and handshakes.
 * Bound into async_fifo. Observes the internal Gray pointers.
 */

`timescale 1ns/1ps

module async_fifo_asserts import cdc_fifo_pkg::*; (
    input logic                  clk_in_i,
    input logic                  clk_out_i,
    input logic                  arst_n_i,
    input logic [ptr_width-1:0]  wr_gray_i,
    input logic [ptr_width-1:0]  rd_gray_i,
    input logic                  data_in_ready_i,
    input logic [elem_width-1:0] data_out_i,
    input logic                  data_out_valid_i,
    input logic                  data_out_ready_i
);

    // Gray pointers step by one bit at most.
    a_wr_gray_step: assert property (@(posedge clk_in_i) disable iff (!arst_n_i)
        $countones(wr_gray_i ^ $past(wr_gray_i)) <= 1)
        else $error("wr_gray changed more than one bit in one write clock");

    a_rd_gray_step: assert property (@(posedge clk_out_i) disable iff (!arst_n_i)
        $countones(rd_gray_i ^ $past(rd_gray_i)) <= 1)
        else $error("rd_gray changed more than one bit in one read clock");

    // No write while full.
    a_wr_hold: assert property (@(posedge clk_in_i) disable iff (!arst_n_i)
        !data_in_ready_i |=> $stable(wr_gray_i))
        else $error("write pointer moved while data_in_ready_o was low");

    // Stalled output holds.
    a_out_hold: assert property (@(posedge clk_out_i) disable iff (!arst_n_i)
        data_out_valid_i && !data_out_ready_i |=> data_out_valid_i && $stable(data_out_i))
        else $error("output changed while stalled by data_out_ready_i");

endmodule

bind async_fifo async_fifo_asserts u_asserts (
    .clk_in_i         (clk_in_i),
    .clk_out_i        (clk_out_i),
    .arst_n_i         (arst_n_i),
    .wr_gray_i        (wr_gray),
    .rd_gray_i        (rd_gray),
    .data_in_ready_i  (data_in_ready_o),
    .data_out_i       (data_out_o),
    .data_out_valid_i (data_out_valid_o),
    .data_out_ready_i (data_out_ready_i)
);

// ==== async_fifo_tb.sv ====
/*
 * Directed testbench for the dual-clock FIFO.
 * Two free-running clocks, a scoreboard queue and an LCG drive the tests.
 * Each side is driven and sampled on the falling edge of its own clock.
 * Stops at the first mismatch or expired wait.
 */

`timescale 1ns/1ps

module async_fifo_tb import cdc_fifo_pkg::*; ();

    localparam int in_half      = 10;    // 20 ns write clock.
    localparam int out_half     = 17;    // 34 ns read clock.
    localparam int wait_limit   = 20;    // Cycles for one handshake event.
    localparam int stream_limit = 2000;  // Cycles for the whole stream.
    localparam int stream_words = 40;

    logic                  arst_n_i;
    logic                  clk_in_i;
    logic                  clk_out_i;
    logic [elem_width-1:0] data_in_i;
    logic                  data_in_valid_i;
    logic                  data_in_ready_o;
    logic [elem_width-1:0] data_out_o;
    logic                  data_out_valid_o;
    logic                  data_out_ready_i;

    logic [elem_width-1:0] sb [$];  // Accepted words, oldest first.
    int unsigned           lcg_state;

    async_fifo dut (
        .arst_n_i         (arst_n_i),
        .clk_in_i         (clk_in_i),
        .data_in_i        (data_in_i),
        .data_in_valid_i  (data_in_valid_i),
        .data_in_ready_o  (data_in_ready_o),
        .clk_out_i        (clk_out_i),
        .data_out_o       (data_out_o),
        .data_out_valid_o (data_out_valid_o),
        .data_out_ready_i (data_out_ready_i)
    );

    always #in_half clk_in_i = ~clk_in_i;
    always #out_half clk_out_i = ~clk_out_i;  // Rising edges never meet a write clock edge.

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: gave up waiting for %s", $time, what);
        stop_run();
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    // Plain 32-bit LCG, upper bits only.
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic wait_in_ready(input string what);
        int waited;
        waited = 0;
        @(negedge clk_in_i);
        while (!data_in_ready_o && waited < wait_limit) begin
            @(negedge clk_in_i);
            waited++;
        end
        if (!data_in_ready_o) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_out_valid(input string what);
        int waited;
        waited = 0;
        @(negedge clk_out_i);
        while (!data_out_valid_o && waited < wait_limit) begin
            @(negedge clk_out_i);
            waited++;
        end
        if (!data_out_valid_o) begin
            report_timeout(what);
        end
    endtask

    // Compare the offered word with the oldest accepted one.
    task automatic match_front();
        if (sb.size() == 0) begin
            $display("error: time %0t: DUT offers a word that was never written", $time);
            stop_run();
        end
        check("data_out_o", 32'(data_out_o), 32'(sb.pop_front()));
    endtask

    task automatic write_word(input logic [elem_width-1:0] value);
        wait_in_ready("data_in_ready_o before a write");
        data_in_i       = value;
        data_in_valid_i = 1'b1;
        sb.push_back(value);  // Taken on the coming rising edge.
        @(negedge clk_in_i);
        data_in_valid_i = 1'b0;
    endtask

    task automatic read_word();
        wait_out_valid("data_out_valid_o before a read");
        match_front();
        data_out_ready_i = 1'b1;  // One rising edge with ready high.
        @(negedge clk_out_i);
        data_out_ready_i = 1'b0;
    endtask

    // Lets both pointer synchronizers catch up.
    task automatic settle();
        repeat (4) @(negedge clk_out_i);
    endtask

    task automatic test_reset_state();
        @(negedge clk_in_i);
        check("data_in_ready_o", 32'(data_in_ready_o), 32'(1));
        check("data_out_valid_o", 32'(data_out_valid_o), 32'(0));
    endtask

    task automatic test_single_word();
        write_word(8'(lcg_next()));
        read_word();
        check("data_out_valid_o", 32'(data_out_valid_o), 32'(0));  // Empty again.
    endtask

    task automatic test_full();
        settle();
        for (int i = 0; i < depth; i++) begin
            write_word(8'(lcg_next()));
        end
        check("data_in_ready_o", 32'(data_in_ready_o), 32'(0));  // Full at once.
        data_in_i       = 8'(lcg_next());  // Extra word, must bounce.
        data_in_valid_i = 1'b1;
        repeat (5) begin
            @(negedge clk_in_i);
            check("data_in_ready_o", 32'(data_in_ready_o), 32'(0));
        end
        data_in_valid_i = 1'b0;
    endtask

    task automatic test_drain();
        logic [elem_width-1:0] first;
        first = sb[0];
        wait_out_valid("data_out_valid_o with the FIFO full");
        repeat (4) begin  // Reader stalls, output holds.
            @(negedge clk_out_i);
            check("data_out_valid_o", 32'(data_out_valid_o), 32'(1));
            check("data_out_o", 32'(data_out_o), 32'(first));
        end
        repeat (depth) read_word();
        check("data_out_valid_o", 32'(data_out_valid_o), 32'(0));
        wait_in_ready("data_in_ready_o after draining");
        repeat (4) begin  // Bounced word never shows up.
            @(negedge clk_out_i);
            check("data_out_valid_o", 32'(data_out_valid_o), 32'(0));
        end
    endtask

    task automatic stream_writer();
        int sent;
        int cycles;
        sent   = 0;
        cycles = 0;
        while (sent < stream_words && cycles < stream_limit) begin
            @(negedge clk_in_i);
            cycles++;
            data_in_valid_i = (lcg_next() % 4) != 0;  // Valid three times in four.
            data_in_i       = 8'(lcg_next());
            if (data_in_valid_i && data_in_ready_o) begin
                sb.push_back(data_in_i);
                sent++;
            end
        end
        @(negedge clk_in_i);
        data_in_valid_i = 1'b0;
        if (sent < stream_words) begin
            report_timeout("the writer to get all stream words accepted");
        end
    endtask

    task automatic stream_reader();
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < stream_words && cycles < stream_limit) begin
            @(negedge clk_out_i);
            cycles++;
            data_out_ready_i = (lcg_next() % 3) != 0;  // Ready two times in three.
            if (data_out_valid_o && data_out_ready_i) begin
                match_front();
                got++;
            end
        end
        @(negedge clk_out_i);
        data_out_ready_i = 1'b0;
        if (got < stream_words) begin
            report_timeout("the reader to receive all stream words");
        end
    endtask

    task automatic test_stream();
        settle();
        fork
            stream_writer();
            stream_reader();
        join
        settle();
        check("data_out_valid_o", 32'(data_out_valid_o), 32'(0));
        check("data_in_ready_o", 32'(data_in_ready_o), 32'(1));
    endtask

    initial begin
        lcg_state        = 32'd11;
        clk_in_i         = 1'b0;
        clk_out_i        = 1'b0;
        arst_n_i         = 1'b0;
        data_in_i        = '0;
        data_in_valid_i  = 1'b0;
        data_out_ready_i = 1'b0;
        repeat (3) @(posedge clk_in_i);
        @(negedge clk_in_i);
        arst_n_i = 1'b1;  // Released away from any read clock edge.
        test_reset_state();
        test_single_word();
        test_full();
        test_drain();
        test_stream();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== async_fifo.f ====
cdc_fifo_pkg.sv
fifo_mem.sv
ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
async_fifo_asserts.sv
async_fifo_tb.sv

// ==== Makefile ====
# Verilator build and run of the dual-clock FIFO testbench.

VERILATOR ?= verilator
TOP       ?= async_fifo_tb
FILELIST  ?= async_fifo.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
